//--- src.f
+incdir+rtl
rtl/soc_mem_pkg.sv
rtl/sram_bank.sv
rtl/data_req_buffer.sv
rtl/data_addr_decoder.sv
rtl/inst_port_arbiter.sv
rtl/soc_mem_top.sv
tb/soc_mem_top_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the memory subsystem testbench with Verilator
set -e
set -o pipefail

cd "$(dirname "$0")"

LOG=sim.log

rm -rf obj_dir
verilator --binary --timing --assert --timescale 1ns/1ps \
    -f src.f --top-module soc_mem_top_tb -o soc_mem_sim

./obj_dir/soc_mem_sim | tee "$LOG"

if grep -q "test failed" "$LOG"; then
    echo "Simulation reported a failure, see $LOG"
    exit 1
fi
echo "Simulation finished, see $LOG"

//--- tb/soc_mem_top_tb.sv
`timescale 1ns/1ps
`include "soc_mem_cfg.svh"

module soc_mem_top_tb import soc_mem_pkg::*; ();

    // Wait limit in cycles for any single loop
    localparam int TMO = 100;
    localparam addr_t INST_BYTES = addr_t'(`SOC_INST_WORDS * 4);
    localparam addr_t DATA_BYTES = addr_t'(`SOC_DATA_WORDS * 4);

    logic  clk_i = 1'b0;
    logic  reset_i;
    logic  instr_req_i;
    addr_t instr_addr_i;
    logic  instr_gnt_o, instr_rvalid_o;
    word_t instr_rdata_o;
    logic  data_req_i, data_we_i;
    be_t   data_be_i;
    addr_t data_addr_i;
    word_t data_wdata_i;
    logic  data_gnt_o, data_rvalid_o, data_err_o;
    word_t data_rdata_o;

    int    errors = 0;
    int    test_cnt = 0;
    int    test_err_base = 0;
    string test_name;
    int    seed = 67;
    logic  data_busy;
    // Sparse model of both banks, keyed by word-aligned byte address
    word_t model [addr_t];
    // Fetch addresses granted and not yet answered
    addr_t fetch_q [$];

    always #4 clk_i = ~clk_i;

    soc_mem_top dut_i (
        .clk_i          (clk_i),
        .reset_i        (reset_i),
        .instr_req_i    (instr_req_i),
        .instr_addr_i   (instr_addr_i),
        .instr_gnt_o    (instr_gnt_o),
        .instr_rvalid_o (instr_rvalid_o),
        .instr_rdata_o  (instr_rdata_o),
        .data_req_i     (data_req_i),
        .data_we_i      (data_we_i),
        .data_be_i      (data_be_i),
        .data_addr_i    (data_addr_i),
        .data_wdata_i   (data_wdata_i),
        .data_gnt_o     (data_gnt_o),
        .data_rvalid_o  (data_rvalid_o),
        .data_err_o     (data_err_o),
        .data_rdata_o   (data_rdata_o)
    );

    ////////////////////////////////////////////////////////////////////////////
    // Reference model
    ////////////////////////////////////////////////////////////////////////////

    // Inside the byte window [base, base + bytes)
    function automatic logic in_window(input addr_t a, input addr_t base, input addr_t bytes);
        return (a >= base) && (a < base + bytes);
    endfunction

    // True when the address hits neither SRAM
    function automatic logic is_unmapped(input addr_t a);
        return !(in_window(a, `SOC_INST_BASE, INST_BYTES) ||
                 in_window(a, `SOC_DATA_BASE, DATA_BYTES));
    endfunction

    // Only enabled byte lanes take new data
    function automatic word_t merge_lanes(input word_t old, input word_t wd, input be_t be);
        word_t w;
        w = old;
        for (int b = 0; b < 4; b++)
            if (be[b])
                w[8*b +: 8] = wd[8*b +: 8];
        return w;
    endfunction

    // Single place where the run ends
    task automatic finish_run(input string why);
        if (why != "")
            $display("%s", why);
        $display("Summary: %0d tests run, %0d errors", test_cnt, errors);
        if (why == "" && errors == 0)
            $display("test passed");
        else
            $display("test failed");
        $finish;
    endtask

    task automatic start_test(input string name);
        test_name     = name;
        test_err_base = errors;
    endtask

    task automatic end_test();
        test_cnt++;
        $display("[%0d] %s done, %0d errors", test_cnt, test_name, errors - test_err_base);
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Core-side drivers
    ////////////////////////////////////////////////////////////////////////////

    // One data access, checked against the model when its rvalid arrives
    task automatic data_access(input logic we, input be_t be, input addr_t addr,
                               input word_t wd);
        int    t;
        addr_t key;
        word_t exp_data;
        logic  exp_err;
        key      = {addr[31:2], 2'b00};
        exp_err  = is_unmapped(addr);
        exp_data = (exp_err || we) ? '0 : model[key];
        @(negedge clk_i);
        data_req_i   = 1'b1;
        data_we_i    = we;
        data_be_i    = be;
        data_addr_i  = addr;
        data_wdata_i = wd;
        t = 0;
        // Grant depends only on buffer state, stable in the low phase
        while (!data_gnt_o) begin
            @(negedge clk_i);
            t++;
            if (t > TMO)
                finish_run($sformatf("Timeout: no data grant for address %h", addr));
        end
        @(negedge clk_i);
        data_req_i = 1'b0;
        t = 0;
        while (!data_rvalid_o) begin
            @(negedge clk_i);
            t++;
            if (t > TMO)
                finish_run($sformatf("Timeout: no data response for address %h", addr));
        end
        assert (data_err_o == exp_err) else begin
            $display("ERR data_err_o got %h exp %h addr %h", data_err_o, exp_err, addr);
            errors++;
        end
        if (!we) begin
            assert (data_rdata_o == exp_data) else begin
                $display("ERR data_rdata_o got %h exp %h addr %h", data_rdata_o, exp_data, addr);
                errors++;
            end
        end
        if (we && !exp_err)
            model[key] = merge_lanes(model.exists(key) ? model[key] : '0, wd, be);
    endtask

    // Back-to-back fetches, one per cycle, then drain
    task automatic fetch_stream(input addr_t base, input int n);
        int t;
        for (int i = 0; i < n; i++) begin
            @(negedge clk_i);
            instr_req_i  = 1'b1;
            instr_addr_i = base + addr_t'(4 * i);
            @(posedge clk_i);
            t = 0;
            while (!instr_gnt_o) begin
                @(posedge clk_i);
                t++;
                if (t > TMO)
                    finish_run("Timeout: fetch request was never granted");
            end
        end
        @(negedge clk_i);
        instr_req_i = 1'b0;
        t = 0;
        while (fetch_q.size() != 0) begin
            @(negedge clk_i);
            t++;
            if (t > TMO)
                finish_run("Timeout: fetch responses never drained");
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Monitors and assertions
    ////////////////////////////////////////////////////////////////////////////

    // Fetch responses return in grant order
    always @(posedge clk_i) begin : fetch_mon
        addr_t a;
        if (!reset_i) begin
            if (instr_rvalid_o) begin
                if (fetch_q.size() == 0) begin
                    $display("Fetch response arrived with no fetch in flight");
                    errors++;
                end else begin
                    a = fetch_q.pop_front();
                    assert (instr_rdata_o == model[a]) else begin
                        $display("ERR instr_rdata_o got %h exp %h addr %h",
                                 instr_rdata_o, model[a], a);
                        errors++;
                    end
                end
            end
            if (instr_req_i && instr_gnt_o)
                fetch_q.push_back(instr_addr_i);
        end
    end

    // Open from acceptance until the matching rvalid
    always_ff @(posedge clk_i, posedge reset_i) begin
        if (reset_i)
            data_busy <= 1'b0;
        else if (data_req_i && data_gnt_o)
            data_busy <= 1'b1;
        else if (data_rvalid_o)
            data_busy <= 1'b0;
    end

    a_gnt_while_busy: assert property (@(posedge clk_i) disable iff (reset_i)
        data_busy |-> !data_gnt_o)
        else begin
            $display("ERR data_gnt_o got %h exp 0 while a request is open", data_gnt_o);
            errors++;
        end

    // Fetch grant follows the request in the same cycle
    a_fetch_gnt: assert property (@(posedge clk_i) disable iff (reset_i)
        instr_gnt_o == instr_req_i)
        else begin
            $display("ERR instr_gnt_o got %h exp %h", instr_gnt_o, instr_req_i);
            errors++;
        end

    a_fetch_latency: assert property (@(posedge clk_i) disable iff (reset_i)
        (instr_req_i && instr_gnt_o) |=> instr_rvalid_o)
        else begin
            $display("Fetch response did not follow its grant by one cycle");
            errors++;
        end

    a_fetch_spurious: assert property (@(posedge clk_i) disable iff (reset_i)
        instr_rvalid_o |-> $past(instr_req_i && instr_gnt_o))
        else begin
            $display("Fetch response seen without a grant the cycle before");
            errors++;
        end

    a_err_needs_rvalid: assert property (@(posedge clk_i) disable iff (reset_i)
        data_err_o |-> data_rvalid_o)
        else begin
            $display("ERR data_rvalid_o got %h exp 1 with data_err_o", data_rvalid_o);
            errors++;
        end

    a_err_zero_data: assert property (@(posedge clk_i) disable iff (reset_i)
        data_err_o |-> (data_rdata_o == '0))
        else begin
            $display("ERR data_rdata_o got %h exp 00000000 on error", data_rdata_o);
            errors++;
        end

    ////////////////////////////////////////////////////////////////////////////
    // Test sequence
    ////////////////////////////////////////////////////////////////////////////

    initial begin
        logic [31:0] rnd;
        int          sel;
        addr_t       addr;
        reset_i      = 1'b1;
        instr_req_i  = 1'b0;
        instr_addr_i = '0;
        data_req_i   = 1'b0;
        data_we_i    = 1'b0;
        data_be_i    = '0;
        data_addr_i  = '0;
        data_wdata_i = '0;
        repeat (8) @(posedge clk_i);
        @(negedge clk_i);
        reset_i = 1'b0;

        start_test("reset state");
        @(negedge clk_i);
        assert (data_gnt_o == 1'b1) else begin
            $display("ERR data_gnt_o got %h exp 1", data_gnt_o);
            errors++;
        end
        assert (instr_rvalid_o == 1'b0) else begin
            $display("ERR instr_rvalid_o got %h exp 0", instr_rvalid_o);
            errors++;
        end
        assert (data_rvalid_o == 1'b0) else begin
            $display("ERR data_rvalid_o got %h exp 0", data_rvalid_o);
            errors++;
        end
        assert (data_err_o == 1'b0) else begin
            $display("ERR data_err_o got %h exp 0", data_err_o);
            errors++;
        end
        end_test();

        start_test("data SRAM write and read-back");
        for (int i = 0; i < 8; i++)
            data_access(1'b1, 4'hf, `SOC_DATA_BASE + addr_t'(4 * i), $random(seed));
        data_access(1'b1, 4'hf, `SOC_DATA_BASE + DATA_BYTES - 4, 32'hcafe_f00d);
        // Mixed lane patterns over the first words
        data_access(1'b1, 4'b0001, `SOC_DATA_BASE + 0, 32'h1111_11aa);
        data_access(1'b1, 4'b0110, `SOC_DATA_BASE + 4, 32'h22bb_cc22);
        data_access(1'b1, 4'b1000, `SOC_DATA_BASE + 8, 32'hdd33_3333);
        data_access(1'b1, 4'b1010, `SOC_DATA_BASE + 12, 32'hee44_ff44);
        for (int i = 0; i < 8; i++)
            data_access(1'b0, 4'hf, `SOC_DATA_BASE + addr_t'(4 * i), '0);
        data_access(1'b0, 4'hf, `SOC_DATA_BASE + DATA_BYTES - 4, '0);
        end_test();

        start_test("program load and fetch");
        for (int i = 0; i < 16; i++)
            data_access(1'b1, 4'hf, `SOC_INST_BASE + addr_t'(4 * i), $random(seed));
        fetch_stream(`SOC_INST_BASE, 16);
        data_access(1'b0, 4'hf, `SOC_INST_BASE + 20, '0);
        end_test();

        start_test("unmapped address");
        data_access(1'b0, 4'hf, `SOC_INST_BASE + INST_BYTES, '0);
        // Would alias word 0 of either bank if it leaked through
        data_access(1'b1, 4'hf, `SOC_INST_BASE + INST_BYTES, 32'hbad0_0001);
        data_access(1'b1, 4'hf, `SOC_DATA_BASE + DATA_BYTES, 32'hbad0_0002);
        data_access(1'b1, 4'h3, 32'h8000_0000, 32'hbad0_0003);
        data_access(1'b0, 4'hf, 32'hffff_fffc, '0);
        for (int i = 0; i < 4; i++) begin
            data_access(1'b0, 4'hf, `SOC_DATA_BASE + addr_t'(4 * i), '0);
            data_access(1'b0, 4'hf, `SOC_INST_BASE + addr_t'(4 * i), '0);
        end
        end_test();

        start_test("fetch and data contention");
        fork
            fetch_stream(`SOC_INST_BASE, 16);
            begin
                repeat (2) @(negedge clk_i);
                data_access(1'b0, 4'hf, `SOC_INST_BASE + 12, '0);
            end
        join
        end_test();

        start_test("random traffic");
        for (int i = 0; i < 60; i++) begin
            rnd = $random(seed);
            sel = int'(rnd % 3);
            // Pool words already hold known data
            case (sel)
                0:       addr = `SOC_INST_BASE + addr_t'(4 * int'(rnd[6:4]));
                1:       addr = `SOC_DATA_BASE + addr_t'(4 * int'(rnd[6:4]));
                default: addr = 32'h0004_0000 + addr_t'(4 * int'(rnd[6:4]));
            endcase
            data_access(rnd[12], (rnd[11:8] == '0) ? 4'hf : rnd[11:8], addr, $random(seed));
        end
        end_test();

        finish_run("");
    end

endmodule

//--- rtl/soc_mem_top.sv
`timescale 1ns/1ps
`include "soc_mem_cfg.svh"

module soc_mem_top import soc_mem_pkg::*; (
    input  logic  clk_i,
    input  logic  reset_i,
    // Instruction-fetch port
    input  logic  instr_req_i,
    input  addr_t instr_addr_i,
    output logic  instr_gnt_o,
    output logic  instr_rvalid_o,
    output word_t instr_rdata_o,
    // Data port
    input  logic  data_req_i,
    input  logic  data_we_i,
    input  be_t   data_be_i,
    input  addr_t data_addr_i,
    input  word_t data_wdata_i,
    output logic  data_gnt_o,
    output logic  data_rvalid_o,
    output logic  data_err_o,
    output word_t data_rdata_o
);

    ////////////////////////////////////////////////////////////////////////////
    // Interconnect
    ////////////////////////////////////////////////////////////////////////////

    // Buffer to decoder
    logic  buf_req, buf_we, buf_gnt;
    be_t   buf_be;
    addr_t buf_addr;
    word_t buf_wdata;

    // Decoder to arbiter
    logic  dsel_req, dsel_we, dsel_gnt, dsel_rvalid;
    be_t   dsel_be;
    addr_t dsel_addr;
    word_t dsel_wdata, dsel_rdata;

    // Decoder to data bank
    logic  dmem_req, dmem_we, dmem_rvalid;
    be_t   dmem_be;
    addr_t dmem_addr;
    word_t dmem_wdata, dmem_rdata;

    // Arbiter to instruction bank
    logic  imem_req, imem_we, imem_rvalid;
    be_t   imem_be;
    addr_t imem_addr;
    word_t imem_wdata, imem_rdata;

    data_req_buffer u_buf (
        .clk_i         (clk_i),
        .reset_i       (reset_i),
        .core_req_i    (data_req_i),
        .core_we_i     (data_we_i),
        .core_be_i     (data_be_i),
        .core_addr_i   (data_addr_i),
        .core_wdata_i  (data_wdata_i),
        .core_gnt_o    (data_gnt_o),
        .core_rvalid_i (data_rvalid_o),
        .buf_req_o     (buf_req),
        .buf_we_o      (buf_we),
        .buf_be_o      (buf_be),
        .buf_addr_o    (buf_addr),
        .buf_wdata_o   (buf_wdata),
        .buf_gnt_i     (buf_gnt)
    );

    data_addr_decoder u_dec (
        .clk_i         (clk_i),
        .reset_i       (reset_i),
        .buf_req_i     (buf_req),
        .buf_we_i      (buf_we),
        .buf_be_i      (buf_be),
        .buf_addr_i    (buf_addr),
        .buf_wdata_i   (buf_wdata),
        .buf_gnt_o     (buf_gnt),
        .dsel_req_o    (dsel_req),
        .dsel_we_o     (dsel_we),
        .dsel_be_o     (dsel_be),
        .dsel_addr_o   (dsel_addr),
        .dsel_wdata_o  (dsel_wdata),
        .dsel_gnt_i    (dsel_gnt),
        .dsel_rvalid_i (dsel_rvalid),
        .dsel_rdata_i  (dsel_rdata),
        .dmem_req_o    (dmem_req),
        .dmem_we_o     (dmem_we),
        .dmem_be_o     (dmem_be),
        .dmem_addr_o   (dmem_addr),
        .dmem_wdata_o  (dmem_wdata),
        .dmem_rvalid_i (dmem_rvalid),
        .dmem_rdata_i  (dmem_rdata),
        .data_rvalid_o (data_rvalid_o),
        .data_rdata_o  (data_rdata_o),
        .data_err_o    (data_err_o)
    );

    inst_port_arbiter u_arb (
        .clk_i          (clk_i),
        .reset_i        (reset_i),
        .instr_req_i    (instr_req_i),
        .instr_addr_i   (instr_addr_i),
        .instr_gnt_o    (instr_gnt_o),
        .instr_rvalid_o (instr_rvalid_o),
        .instr_rdata_o  (instr_rdata_o),
        .dsel_req_i     (dsel_req),
        .dsel_we_i      (dsel_we),
        .dsel_be_i      (dsel_be),
        .dsel_addr_i    (dsel_addr),
        .dsel_wdata_i   (dsel_wdata),
        .dsel_gnt_o     (dsel_gnt),
        .dsel_rvalid_o  (dsel_rvalid),
        .dsel_rdata_o   (dsel_rdata),
        .mem_req_o      (imem_req),
        .mem_we_o       (imem_we),
        .mem_be_o       (imem_be),
        .mem_addr_o     (imem_addr),
        .mem_wdata_o    (imem_wdata),
        .mem_rvalid_i   (imem_rvalid),
        .mem_rdata_i    (imem_rdata)
    );

    ////////////////////////////////////////////////////////////////////////////
    // Memories
    ////////////////////////////////////////////////////////////////////////////

    sram_bank #(
        .DEPTH_WORDS (`SOC_INST_WORDS)
    ) inst_bank (
        .clk_i    (clk_i),
        .reset_i  (reset_i),
        .req_i    (imem_req),
        .we_i     (imem_we),
        .be_i     (imem_be),
        .addr_i   (imem_addr),
        .wdata_i  (imem_wdata),
        .rvalid_o (imem_rvalid),
        .rdata_o  (imem_rdata)
    );

    sram_bank #(
        .DEPTH_WORDS (`SOC_DATA_WORDS)
    ) data_bank (
        .clk_i    (clk_i),
        .reset_i  (reset_i),
        .req_i    (dmem_req),
        .we_i     (dmem_we),
        .be_i     (dmem_be),
        .addr_i   (dmem_addr),
        .wdata_i  (dmem_wdata),
        .rvalid_o (dmem_rvalid),
        .rdata_o  (dmem_rdata)
    );

endmodule

//--- rtl/inst_port_arbiter.sv
`timescale 1ns/1ps

module inst_port_arbiter import soc_mem_pkg::*; (
    input  logic  clk_i,
    input  logic  reset_i,
    // Fetch side
    input  logic  instr_req_i,
    input  addr_t instr_addr_i,
    output logic  instr_gnt_o,
    output logic  instr_rvalid_o,
    output word_t instr_rdata_o,
    // Data side
    input  logic  dsel_req_i,
    input  logic  dsel_we_i,
    input  be_t   dsel_be_i,
    input  addr_t dsel_addr_i,
    input  word_t dsel_wdata_i,
    output logic  dsel_gnt_o,
    output logic  dsel_rvalid_o,
    output word_t dsel_rdata_o,
    // Bank side
    output logic  mem_req_o,
    output logic  mem_we_o,
    output be_t   mem_be_o,
    output addr_t mem_addr_o,
    output word_t mem_wdata_o,
    input  logic  mem_rvalid_i,
    input  word_t mem_rdata_i
);

    // High when the response in flight is for the data side
    logic owner_data_q;

    // Fetch always wins the single bank port
    assign instr_gnt_o = instr_req_i;
    assign dsel_gnt_o  = dsel_req_i & ~instr_req_i;

    assign mem_req_o   = instr_req_i | dsel_req_i;
    assign mem_addr_o  = instr_req_i ? instr_addr_i : dsel_addr_i;
    // Fetches never write
    assign mem_we_o    = dsel_gnt_o & dsel_we_i;
    assign mem_be_o    = dsel_be_i;
    assign mem_wdata_o = dsel_wdata_i;

    always_ff @(posedge clk_i, posedge reset_i) begin
        if (reset_i)
            owner_data_q <= 1'b0;
        else
            owner_data_q <= dsel_gnt_o;
    end

    // Route the bank response to last cycle's winner
    assign instr_rvalid_o = mem_rvalid_i & ~owner_data_q;
    assign dsel_rvalid_o  = mem_rvalid_i & owner_data_q;
    assign instr_rdata_o  = mem_rdata_i;
    assign dsel_rdata_o   = mem_rdata_i;

    a_grant_excl: assert property (@(posedge clk_i) disable iff (reset_i)
        !(instr_gnt_o && dsel_gnt_o));

    // Fetch latency through the bank is exactly one cycle
    a_fetch_latency: assert property (@(posedge clk_i) disable iff (reset_i)
        instr_gnt_o |=> instr_rvalid_o);

endmodule

//--- rtl/data_addr_decoder.sv
`timescale 1ns/1ps
`include "soc_mem_cfg.svh"

module data_addr_decoder import soc_mem_pkg::*; (
    input  logic  clk_i,
    input  logic  reset_i,
    // Buffer side
    input  logic  buf_req_i,
    input  logic  buf_we_i,
    input  be_t   buf_be_i,
    input  addr_t buf_addr_i,
    input  word_t buf_wdata_i,
    output logic  buf_gnt_o,
    // Instruction bank through the arbiter
    output logic  dsel_req_o,
    output logic  dsel_we_o,
    output be_t   dsel_be_o,
    output addr_t dsel_addr_o,
    output word_t dsel_wdata_o,
    input  logic  dsel_gnt_i,
    input  logic  dsel_rvalid_i,
    input  word_t dsel_rdata_i,
    // Data bank
    output logic  dmem_req_o,
    output logic  dmem_we_o,
    output be_t   dmem_be_o,
    output addr_t dmem_addr_o,
    output word_t dmem_wdata_o,
    input  logic  dmem_rvalid_i,
    input  word_t dmem_rdata_i,
    // Core response
    output logic  data_rvalid_o,
    output word_t data_rdata_o,
    output logic  data_err_o
);

    localparam addr_t INST_BYTES = addr_t'(`SOC_INST_WORDS * 4);
    localparam addr_t DATA_BYTES = addr_t'(`SOC_DATA_WORDS * 4);

    addr_t   inst_off;
    addr_t   data_off;
    target_e tgt;
    target_e resp_tgt_q;
    logic    err_q;

    ////////////////////////////////////////////////////////////////////////////
    // Address map
    ////////////////////////////////////////////////////////////////////////////

    // Offsets wrap below the base, so one compare per region
    assign inst_off = buf_addr_i - addr_t'(`SOC_INST_BASE);
    assign data_off = buf_addr_i - addr_t'(`SOC_DATA_BASE);

    always_comb begin
        if (inst_off < INST_BYTES)
            tgt = TGT_INST;
        else if (data_off < DATA_BYTES)
            tgt = TGT_DATA;
        else
            tgt = TGT_NONE;
    end

    // Request fan-out, banks see region offsets
    assign dsel_req_o   = buf_req_i & (tgt == TGT_INST);
    assign dsel_we_o    = buf_we_i;
    assign dsel_be_o    = buf_be_i;
    assign dsel_addr_o  = inst_off;
    assign dsel_wdata_o = buf_wdata_i;

    assign dmem_req_o   = buf_req_i & (tgt == TGT_DATA);
    assign dmem_we_o    = buf_we_i;
    assign dmem_be_o    = buf_be_i;
    assign dmem_addr_o  = data_off;
    assign dmem_wdata_o = buf_wdata_i;

    // Data bank and error path never stall
    assign buf_gnt_o = (tgt == TGT_INST) ? dsel_gnt_i : 1'b1;

    ////////////////////////////////////////////////////////////////////////////
    // Response steering
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk_i, posedge reset_i) begin
        if (reset_i) begin
            resp_tgt_q <= TGT_NONE;
            err_q      <= 1'b0;
        end else begin
            err_q <= buf_req_i & buf_gnt_o & (tgt == TGT_NONE);
            if (buf_req_i & buf_gnt_o)
                resp_tgt_q <= tgt;
        end
    end

    assign data_rvalid_o = dsel_rvalid_i | dmem_rvalid_i | err_q;
    assign data_err_o    = err_q;

    // Unmapped reads return zero
    always_comb begin
        case (resp_tgt_q)
            TGT_INST: data_rdata_o = dsel_rdata_i;
            TGT_DATA: data_rdata_o = dmem_rdata_i;
            default:  data_rdata_o = '0;
        endcase
    end

    // One response per cycle across arbiter, data bank and error path
    a_one_source: assert property (@(posedge clk_i) disable iff (reset_i)
        $onehot0({dsel_rvalid_i, dmem_rvalid_i, err_q}));

    // Arbiter response only for a request routed there
    a_dsel_owner: assert property (@(posedge clk_i) disable iff (reset_i)
        dsel_rvalid_i |-> (resp_tgt_q == TGT_INST));

endmodule

//--- rtl/data_req_buffer.sv
`timescale 1ns/1ps

module data_req_buffer import soc_mem_pkg::*; (
    input  logic  clk_i,
    input  logic  reset_i,
    // Core side
    input  logic  core_req_i,
    input  logic  core_we_i,
    input  be_t   core_be_i,
    input  addr_t core_addr_i,
    input  word_t core_wdata_i,
    output logic  core_gnt_o,
    input  logic  core_rvalid_i,
    // Downstream side
    output logic  buf_req_o,
    output logic  buf_we_o,
    output be_t   buf_be_o,
    output addr_t buf_addr_o,
    output word_t buf_wdata_o,
    input  logic  buf_gnt_i
);

    buf_state_e state_q;
    logic       accept;

    // Only one request outstanding, so accept only when empty
    assign core_gnt_o = (state_q == BUF_IDLE);
    assign accept     = core_req_i & core_gnt_o;

    // Replay downstream until granted
    assign buf_req_o  = (state_q == BUF_ISSUE);

    always_ff @(posedge clk_i, posedge reset_i) begin
        if (reset_i) begin
            state_q <= BUF_IDLE;
        end else begin
            case (state_q)
                BUF_IDLE:  if (accept)        state_q <= BUF_ISSUE;
                BUF_ISSUE: if (buf_gnt_i)     state_q <= BUF_WAIT;
                BUF_WAIT:  if (core_rvalid_i) state_q <= BUF_IDLE;
                default:                      state_q <= BUF_IDLE;
            endcase
        end
    end

    // Payload held from acceptance until the response
    always_ff @(posedge clk_i) begin
        if (accept) begin
            buf_we_o    <= core_we_i;
            buf_be_o    <= core_be_i;
            buf_addr_o  <= core_addr_i;
            buf_wdata_o <= core_wdata_i;
        end
    end

    // Steered response must belong to the request in flight
    a_rvalid_in_wait: assert property (@(posedge clk_i) disable iff (reset_i)
        core_rvalid_i |-> (state_q == BUF_WAIT));

endmodule

//--- rtl/sram_bank.sv
`timescale 1ns/1ps

module sram_bank import soc_mem_pkg::*; #(
    parameter int DEPTH_WORDS = 2048
) (
    input  logic  clk_i,
    input  logic  reset_i,
    input  logic  req_i,
    input  logic  we_i,
    input  be_t   be_i,
    input  addr_t addr_i,
    input  word_t wdata_i,
    output logic  rvalid_o,
    output word_t rdata_o
);

    localparam int IDX_W  = $clog2(DEPTH_WORDS);
    localparam int LANES  = $bits(be_t);
    localparam int LANE_W = $bits(word_t) / LANES;

    word_t            mem [DEPTH_WORDS];
    logic [IDX_W-1:0] idx;

    // Word index, byte offset dropped
    assign idx = addr_i[IDX_W+1:2];

    // Write enabled lanes, read old word on every access
    always_ff @(posedge clk_i) begin
        if (req_i) begin
            rdata_o <= mem[idx];
            if (we_i) begin
                for (int b = 0; b < LANES; b++) begin
                    if (be_i[b])
                        mem[idx][b*LANE_W +: LANE_W] <= wdata_i[b*LANE_W +: LANE_W];
                end
            end
        end
    end

    // Every request answered next cycle
    always_ff @(posedge clk_i, posedge reset_i) begin
        if (reset_i)
            rvalid_o <= 1'b0;
        else
            rvalid_o <= req_i;
    end

endmodule

//--- rtl/soc_mem_pkg.sv
`include "soc_mem_cfg.svh"

package soc_mem_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // Bus types
    ////////////////////////////////////////////////////////////////////////////

    // Byte address as issued by the core
    typedef logic [`SOC_ADDR_W-1:0] addr_t;

    // Data word on both ports
    typedef logic [`SOC_DATA_W-1:0] word_t;

    // Byte lane enables
    typedef logic [`SOC_BE_W-1:0]   be_t;

    ////////////////////////////////////////////////////////////////////////////
    // Enums
    ////////////////////////////////////////////////////////////////////////////

    // Request buffer FSM
    typedef enum logic [1:0] {
        BUF_IDLE,
        BUF_ISSUE,
        BUF_WAIT
    } buf_state_e;

    // Address decode result
    typedef enum logic [1:0] {
        TGT_INST,
        TGT_DATA,
        TGT_NONE
    } target_e;

endpackage

//--- rtl/soc_mem_cfg.svh
`ifndef SOC_MEM_CFG_SVH
`define SOC_MEM_CFG_SVH

////////////////////////////////////////////////////////////////////////////
// Bus widths
////////////////////////////////////////////////////////////////////////////

// Byte address
`define SOC_ADDR_W      32
// One data word
`define SOC_DATA_W      32
// One enable per byte lane
`define SOC_BE_W        4

////////////////////////////////////////////////////////////////////////////
// Address map
////////////////////////////////////////////////////////////////////////////

// Instruction SRAM, 8 KB
`define SOC_INST_BASE   32'h0000_0000
`define SOC_INST_WORDS  2048

// Data SRAM, 8 KB
`define SOC_DATA_BASE   32'h0001_0000
`define SOC_DATA_WORDS  2048

`endif
